//--- src/cache_geom_pkg.sv
package cache_geom_pkg;

    //////////////////////////////
    // Address geometry
    //////////////////////////////

    localparam int ADDR_W     = 16;                 // Byte address
    localparam int OFFSET_W   = 2;                  // 4-byte blocks
    localparam int BLOCK_W    = ADDR_W - OFFSET_W;  // Block number width

    //////////////////////////////
    // Tag store capacity
    //////////////////////////////

    localparam int NUM_BLOCKS = 8;
    localparam int INDEX_W    = $clog2(NUM_BLOCKS); // Widest set index, also widest way select

    //////////////////////////////
    // Controller counters
    //////////////////////////////

    // Weighted conflict score that moves the cache one associativity step up
    localparam int SWITCH_THRESHOLD = 8;

    localparam int CNT_W  = 8;   // Switch counter
    localparam int STAT_W = 16;  // Request and hit statistics

endpackage

//--- src/mutative_types.sv
package mutative_types;

    import cache_geom_pkg::*;

    // Log2 of the way count equals the encoding
    typedef enum logic [1:0] {
        SETUP_DM = 2'd0,  // 8 sets x 1 way
        SETUP_2W = 2'd1,  // 4 sets x 2 ways
        SETUP_4W = 2'd2,  // 2 sets x 4 ways
        SETUP_FA = 2'd3   // 1 set x 8 ways
    } setup_e;

    typedef enum logic [1:0] {
        CLS_HIT        = 2'd0,
        CLS_COMPULSORY = 2'd1,
        CLS_CONFLICT   = 2'd2,
        CLS_CAPACITY   = 2'd3
    } miss_class_e;

    //////////////////////////////
    // Address views
    //////////////////////////////

    typedef struct packed {
        logic [BLOCK_W-1:0]  block;
        logic [OFFSET_W-1:0] offset;
    } shadow_view_t;

    // Index is the widest one; the real array masks it down per mode
    typedef struct packed {
        logic [ADDR_W-INDEX_W-OFFSET_W-1:0] upper;
        logic [INDEX_W-1:0]                 index;
        logic [OFFSET_W-1:0]                offset;
    } set_view_t;

    typedef union packed {
        shadow_view_t shadow;
        set_view_t    set;
    } cache_addr_u;

endpackage

//--- src/config_tag_array.sv
`timescale 1ns/1ps

module config_tag_array
    import cache_geom_pkg::*, mutative_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        lookup_en,
    input  logic        fill_en,
    input  cache_addr_u addr,
    input  setup_e      setup,

    output logic        real_cache_valid,
    output logic        real_cache_hit,
    output logic        real_cache_full
);

    // Entry number is {set, way}; the set field narrows as ways widen
    logic [BLOCK_W-1:0]    tags [NUM_BLOCKS];
    logic [NUM_BLOCKS-1:0] valid;
    logic [INDEX_W-1:0]    rr_ptr [NUM_BLOCKS];  // One per possible set
    setup_e                setup_last;

    cache_addr_u           addr_r;

    logic [NUM_BLOCKS-1:0] eff_valid;
    logic [NUM_BLOCKS-1:0] in_set;
    logic [NUM_BLOCKS-1:0] hit_vec;
    logic [INDEX_W-1:0]    set_idx;
    logic [INDEX_W-1:0]    way_mask;
    logic [INDEX_W-1:0]    fill_idx;
    logic                  mode_change;

    //////////////////////////////
    // Set decode and search
    //////////////////////////////

    assign mode_change = (setup != setup_last);
    assign eff_valid   = mode_change ? '0 : valid;  // Flush pending, nothing counts

    assign set_idx  = addr_r.set.index & ({INDEX_W{1'b1}} >> setup);
    assign way_mask = ~({INDEX_W{1'b1}} << setup);
    assign fill_idx = (set_idx << setup) | (rr_ptr[set_idx] & way_mask);

    always_comb begin
        for (int e = 0; e < NUM_BLOCKS; e++) begin
            in_set[e]  = ((INDEX_W'(e) >> setup) == set_idx);
            hit_vec[e] = eff_valid[e] && in_set[e] && (tags[e] == addr_r.shadow.block);
        end
    end

    assign real_cache_hit   = |hit_vec;
    assign real_cache_valid = |(eff_valid & in_set);
    assign real_cache_full  = &(eff_valid | ~in_set);

    //////////////////////////////
    // Lookup register and fill
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            addr_r <= addr;
        end
        if (fill_en) begin
            tags[fill_idx] <= addr_r.shadow.block;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid      <= '0;
            setup_last <= SETUP_DM;
            for (int s = 0; s < NUM_BLOCKS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else begin
            if (mode_change) begin
                // New set/way split, old entries no longer line up
                valid      <= '0;
                setup_last <= setup;
                for (int s = 0; s < NUM_BLOCKS; s++) begin
                    rr_ptr[s] <= '0;
                end
            end
            if (fill_en) begin
                valid[fill_idx] <= 1'b1;  // Overrides the flush for this entry
                rr_ptr[set_idx] <= rr_ptr[set_idx] + 1'b1;
            end
        end
    end

    // Controller only fills on a real-array miss
    a_no_fill_on_hit: assert property (@(posedge clk) disable iff (rst)
        fill_en |-> !real_cache_hit)
        else $error("fill issued while the real array hits");

endmodule

//--- src/shadow_assoc_tags.sv
`timescale 1ns/1ps

module shadow_assoc_tags
    import cache_geom_pkg::*, mutative_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        lookup_en,
    input  logic        fill_en,
    input  cache_addr_u addr,

    output logic        full_assoc_hit,
    output logic        full_assoc_full
);

    logic [BLOCK_W-1:0]    tags [NUM_BLOCKS];
    logic [NUM_BLOCKS-1:0] valid;
    logic [INDEX_W-1:0]    fifo_ptr;   // Oldest entry once full

    cache_addr_u           addr_r;
    logic [NUM_BLOCKS-1:0] hit_vec;
    logic                  do_fill;

    //////////////////////////////
    // Parallel search
    //////////////////////////////

    always_comb begin
        for (int e = 0; e < NUM_BLOCKS; e++) begin
            hit_vec[e] = valid[e] && (tags[e] == addr_r.shadow.block);
        end
    end

    assign full_assoc_hit  = |hit_vec;
    assign full_assoc_full = &valid;

    // A shadow hit keeps the block already here
    assign do_fill = fill_en && !full_assoc_hit;

    //////////////////////////////
    // Update
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            addr_r <= addr;
        end
        if (do_fill) begin
            tags[fifo_ptr] <= addr_r.shadow.block;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= '0;
            fifo_ptr <= '0;
        end else if (do_fill) begin
            valid[fifo_ptr] <= 1'b1;
            fifo_ptr        <= fifo_ptr + 1'b1;  // Wraps over all 8 entries
        end
    end

endmodule

//--- src/mutative_control.sv
`timescale 1ns/1ps

module mutative_control
    import cache_geom_pkg::*, mutative_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_req,
    input  logic        mem_ready,
    input  logic        real_cache_valid,
    input  logic        real_cache_hit,
    input  logic        real_cache_full,
    input  logic        full_assoc_hit,
    input  logic        full_assoc_full,

    output logic        lookup_en,
    output logic        fill_en,
    output setup_e      setup,
    output logic        resp_valid,
    output logic        resp_hit,
    output miss_class_e resp_class
);

    enum logic [1:0] {
        s_idle, s_update, s_waiting
    } state, state_next;

    logic [CNT_W-1:0]  switch_counter, switch_counter_next;
    setup_e            setup_next;

    miss_class_e       cls;        // Class of the request in update
    miss_class_e       pend_cls;   // Held while waiting on mem_ready
    miss_class_e       resp_class_next;
    logic              resp_valid_next;

    assign lookup_en = (state == s_idle) && cpu_req;
    assign fill_en   = (state == s_update) && !real_cache_hit;

    //////////////////////////////
    // Miss classification
    //////////////////////////////

    always_comb begin
        if (real_cache_hit)
            cls = CLS_HIT;
        else if (!real_cache_valid)
            cls = CLS_COMPULSORY;
        else if (full_assoc_hit || !real_cache_full)
            cls = CLS_CONFLICT;
        else if (full_assoc_full)
            cls = CLS_CAPACITY;
        else
            cls = CLS_COMPULSORY;  // A shadow miss before any shadow eviction means first touch
    end

    //////////////////////////////
    // FSM and counters
    //////////////////////////////

    always_comb begin
        state_next           = state;
        setup_next           = setup;
        switch_counter_next  = switch_counter;
        resp_valid_next      = 1'b0;
        resp_class_next      = pend_cls;

        unique case (state)
            s_idle: begin
                if (switch_counter >= CNT_W'(SWITCH_THRESHOLD)) begin
                    switch_counter_next = '0;
                    if (setup != SETUP_FA)
                        setup_next = setup_e'(setup + 2'd1);
                end
                if (cpu_req)
                    state_next = s_update;
            end
            s_update: begin
                case (cls)
                    CLS_CONFLICT: switch_counter_next = switch_counter + 2'd2;
                    CLS_CAPACITY: begin
                        if (switch_counter != '0)
                            switch_counter_next = switch_counter - 1'b1;
                    end
                    default: ;
                endcase
                resp_class_next = cls;
                resp_valid_next = mem_ready;
                state_next      = mem_ready ? s_idle : s_waiting;
            end
            s_waiting: begin
                if (mem_ready) begin
                    resp_valid_next = 1'b1;
                    state_next      = s_idle;
                end
            end
            default: state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= s_idle;
            setup           <= SETUP_DM;
            switch_counter  <= '0;
            resp_valid      <= 1'b0;
        end else begin
            state           <= state_next;
            setup           <= setup_next;
            switch_counter  <= switch_counter_next;
            resp_valid      <= resp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_update)
            pend_cls <= cls;
        resp_class <= resp_class_next;
        resp_hit   <= (resp_class_next == CLS_HIT);
    end

    a_setup_monotonic: assert property (@(posedge clk) disable iff (rst)
        setup >= $past(setup))
        else $error("setup moved to a lower associativity");

    a_fill_lookup_excl: assert property (@(posedge clk) disable iff (rst)
        !(fill_en && lookup_en))
        else $error("fill and lookup in the same cycle");

endmodule

//--- src/mutative_cache_top.sv
`timescale 1ns/1ps

module mutative_cache_top
    import mutative_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_req,
    input  cache_addr_u cpu_addr,
    input  logic        mem_ready,

    output logic        resp_valid,
    output logic        resp_hit,
    output miss_class_e resp_class,
    output setup_e      setup
);

    logic lookup_en;
    logic fill_en;
    logic real_cache_valid;
    logic real_cache_hit;
    logic real_cache_full;
    logic full_assoc_hit;
    logic full_assoc_full;

    //////////////////////////////
    // Controller
    //////////////////////////////

    mutative_control u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .cpu_req          (cpu_req),
        .mem_ready        (mem_ready),
        .real_cache_valid (real_cache_valid),
        .real_cache_hit   (real_cache_hit),
        .real_cache_full  (real_cache_full),
        .full_assoc_hit   (full_assoc_hit),
        .full_assoc_full  (full_assoc_full),
        .lookup_en        (lookup_en),
        .fill_en          (fill_en),
        .setup            (setup),
        .resp_valid       (resp_valid),
        .resp_hit         (resp_hit),
        .resp_class       (resp_class)
    );

    //////////////////////////////
    // Tag stores
    //////////////////////////////

    config_tag_array u_real (
        .clk              (clk),
        .rst              (rst),
        .lookup_en        (lookup_en),
        .fill_en          (fill_en),
        .addr             (cpu_addr),
        .setup            (setup),
        .real_cache_valid (real_cache_valid),
        .real_cache_hit   (real_cache_hit),
        .real_cache_full  (real_cache_full)
    );

    shadow_assoc_tags u_shadow (  // Reference for miss classes
        .clk              (clk),
        .rst              (rst),
        .lookup_en        (lookup_en),
        .fill_en          (fill_en),
        .addr             (cpu_addr),
        .full_assoc_hit   (full_assoc_hit),
        .full_assoc_full  (full_assoc_full)
    );

endmodule

//--- tb/mutative_tb.sv
`timescale 1ns/1ps

module mutative_tb
    import cache_geom_pkg::*, mutative_types::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 5;
    localparam int READY_DELAY     = 4;    // Cycles mem_ready stays low when a line asks for it
    localparam int CYCLES_PER_TEST = 20;
    localparam int WATCHDOG_SLACK  = 100;

    logic        clk;
    logic        rst;
    logic        cpu_req;
    cache_addr_u cpu_addr;
    logic        mem_ready;
    logic        resp_valid;
    logic        resp_hit;
    miss_class_e resp_class;
    setup_e      setup;

    // One entry per request line of the data file
    logic [ADDR_W-1:0] vec_addr[$];
    logic              vec_ready[$];
    logic              vec_hit[$];
    miss_class_e       vec_class[$];
    setup_e            vec_setup[$];
    string             vec_name[$];
    int                num_tests = 0;

    mutative_cache_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_addr   (cpu_addr),
        .mem_ready  (mem_ready),
        .resp_valid (resp_valid),
        .resp_hit   (resp_hit),
        .resp_class (resp_class),
        .setup      (setup)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Reporting and compares
    //////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH %s resp_hit expected %0b actual %0b", name, exp, act));
    endtask

    task automatic check_class(input string name, input miss_class_e exp, input miss_class_e act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH %s resp_class expected %s actual %s (%0d)",
                                name, exp.name(), act.name(), act));
    endtask

    task automatic check_setup(input string name, input setup_e exp, input setup_e act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH %s setup expected %s actual %s (%0d)",
                                name, exp.name(), act.name(), act));
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic load_vectors();
        int                fd;
        int                fields;
        int                ready;
        int                hit;
        int                cls;
        int                stp;
        string             line;
        string             name;
        logic [ADDR_W-1:0] addr;
        fd = $fopen("tb/mutative_input.dat", "r");
        if (fd == 0) begin
            abort_run("could not open tb/mutative_input.dat for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.substr(0, 1) == "//")
                    continue;  // Blank or comment line
                fields = $sscanf(line, "%h %d %d %d %d %s", addr, ready, hit, cls, stp, name);
                if (fields != 6) begin
                    abort_run({"data file line could not be parsed: ", line});
                end else begin
                    vec_addr.push_back(addr);
                    vec_ready.push_back(ready[0]);
                    vec_hit.push_back(hit[0]);
                    vec_class.push_back(miss_class_e'(cls));
                    vec_setup.push_back(setup_e'(stp));
                    vec_name.push_back(name);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_request(input int idx);
        int waited;
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_addr  <= cache_addr_u'(vec_addr[idx]);
        mem_ready <= vec_ready[idx];
        @(posedge clk);
        cpu_req   <= 1'b0;  // Single-cycle strobe
        waited = 0;
        @(negedge clk);
        while (!resp_valid) begin
            waited++;
            if (!mem_ready && waited == READY_DELAY) begin
                @(posedge clk);
                mem_ready <= 1'b1;
            end
            @(negedge clk);
        end
        if (!vec_ready[idx] && waited <= READY_DELAY)
            abort_run({"response arrived while mem_ready was still low in ", vec_name[idx]});
        check_hit(vec_name[idx], vec_hit[idx], resp_hit);
        check_class(vec_name[idx], vec_class[idx], resp_class);
        @(negedge clk);  // A mode step lands in the idle cycle after the response
        check_setup(vec_name[idx], vec_setup[idx], setup);
    endtask

    initial begin
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_addr  = '0;
        mem_ready = 1'b1;
        load_vectors();
        num_tests = vec_addr.size();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < num_tests; i++)
            run_request(i);
        if (num_tests > 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("data file held no request lines");
        end
    end

    // Watchdog
    initial begin
        wait (num_tests > 0);
        #((num_tests * CYCLES_PER_TEST + WATCHDOG_SLACK + RESET_CYCLES) * CLK_PERIOD);
        abort_run("timeout: the DUT stopped answering requests");
    end

endmodule

//--- tb/mutative_input.dat
// address mem_ready expected_hit expected_class expected_setup name
// Class codes 0 hit 1 compulsory 2 conflict 3 capacity and setup codes 0 DM 1 2W 2 4W 3 FA
0010 1 0 1 0 first_touch
0010 1 1 0 0 repeat_hit
0030 1 0 1 0 same_index_new
0010 1 0 2 0 dm_conflict_a1
0030 1 0 2 0 dm_conflict_b1
0010 1 0 2 0 dm_conflict_a2
0030 1 0 2 1 dm_conflict_step
0010 1 0 1 1 flushed_after_step
0030 1 0 2 1 two_way_second
0010 1 1 0 1 two_way_hit_a
0030 1 1 0 1 two_way_hit_b
0000 1 0 1 1 stream_b0
0020 1 0 1 1 stream_b8
0040 1 0 1 1 stream_b16
0050 1 0 1 1 stream_b20
0060 1 0 1 1 stream_b24
0070 1 0 1 1 stream_b28
0080 1 0 3 1 capacity_b32
0090 1 0 3 1 capacity_b36
00a0 1 0 3 1 capacity_b40
0020 0 0 2 1 late_ready_conflict
0020 0 1 0 1 late_ready_hit
00a0 1 1 0 1 final_hit

//--- verilog.f
src/cache_geom_pkg.sv
src/mutative_types.sv
src/config_tag_array.sv
src/shadow_assoc_tags.sv
src/mutative_control.sv
src/mutative_cache_top.sv
tb/mutative_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module mutative_tb -f verilog.f -o mutative_sim \
    || exit 1
sim_out=$(./obj_dir/mutative_sim 2>&1)
echo "$sim_out"
grep -q "Regression passed" <<< "$sim_out" && exit 0 || exit 1
